/* logic/action_queue.sv */
`timescale 1ns/10ps

module action_queue
	import tmip_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid2,
	input logic [2:0] action,
	input logic done,
	output gray_mode_e gray_mode,
	output logic neg,
	output logic flip,
	output logic start
);

	action_e act;
	logic accept;
	logic busy;
	logic first_pending;

	assign act = action_e'(action);
	assign accept = in_valid2 && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gray_mode <= gray_max;
			neg <= 1'b0;
			flip <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			first_pending <= 1'b1;
		end else begin
			start <= 1'b0;
			if (done) begin
				busy <= 1'b0;
				neg <= 1'b0;
				flip <= 1'b0;
			end else if (accept && first_pending) begin
				// first action of a set picks the plane
				gray_mode <= gray_mode_e'(action[1:0]);
				first_pending <= 1'b0;
			end else if (accept) begin
				// negative and flip commute, only parity matters
				case (act)
					act_neg: neg <= !neg;
					act_flip: flip <= !flip;
					act_conv: begin
						start <= 1'b1;
						busy <= 1'b1;
						first_pending <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// no actions while a set is still in the engine
	a_no_action_busy: assert property (
		@(posedge clk) disable iff (!rst_n) busy |-> !in_valid2
	);

endmodule

/* logic/corr_engine.sv */
`timescale 1ns/10ps
`include "tmip_defines.svh"

module corr_engine
	import tmip_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input side_t side,
	input pix_t weights [`TMIP_TAPS],
	input gray_mode_e gray_mode,
	input logic neg,
	input logic flip,
	input pix_t gray_max_px,
	input pix_t gray_avg_px,
	input pix_t gray_wgt_px,
	output addr_t rd_addr,
	output acc_t word,
	output logic word_load,
	output logic last,
	output logic done
);

	corr_state_e state;
	logic [$clog2(`TMIP_SLOT)-1:0] cnt;
	side_t x;
	side_t y;
	logic slot_end;
	logic last_px;
	logic issue;
	tap_t tap;
	logic [1:0] tap_row;
	logic [1:0] tap_col;
	side_t src_y;
	side_t src_x;
	side_t col;
	logic tap_in;
	logic tap_use_q;
	logic tap_in_q;
	tap_t tap_idx_q;
	pix_t px_sel;
	pix_t px_eff;
	logic [2*`TMIP_PIX_W-1:0] prod;
	acc_t acc;

	assign slot_end = (cnt == ($bits(cnt))'(`TMIP_SLOT-1));
	assign last_px = (x == side - side_t'(1)) && (y == side - side_t'(1));
	assign issue = (state == corr_fetch) && (cnt < ($bits(cnt))'(`TMIP_TAPS));
	assign tap = tap_t'(cnt);

	// ====================
	// tap addressing
	// ====================
	always_comb begin
		tap_row = 2'd0;
		tap_col = tap[1:0];
		if (tap >= tap_t'(6)) begin
			tap_row = 2'd2;
			tap_col = 2'(tap - tap_t'(6));
		end else if (tap >= tap_t'(3)) begin
			tap_row = 2'd1;
			tap_col = 2'(tap - tap_t'(3));
		end
	end

	// source position offset by one so padding is a compare with 0
	assign src_y = y + side_t'(tap_row);
	assign src_x = x + side_t'(tap_col);
	assign tap_in = (src_y != '0) && (src_y <= side) && (src_x != '0) && (src_x <= side);
	assign col = flip ? side - src_x : src_x - side_t'(1);
	assign rd_addr = tap_in ?
		addr_t'(src_y - side_t'(1)) * addr_t'(side) + addr_t'(col) : '0;

	// ====================
	// multiply and accumulate
	// ====================
	always_comb begin
		case (gray_mode)
			gray_avg: px_sel = gray_avg_px;
			gray_wgt: px_sel = gray_wgt_px;
			default: px_sel = gray_max_px;
		endcase
		// 255 - p
		px_eff = neg ? ~px_sel : px_sel;
		prod = tap_in_q ? px_eff * weights[tap_idx_q] : '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_use_q <= 1'b0;
		end else begin
			tap_use_q <= issue;
		end
	end

	always_ff @(posedge clk) begin
		tap_in_q <= tap_in;
		tap_idx_q <= tap;
		if (tap_use_q) begin
			acc <= (tap_idx_q == '0) ? acc_t'(prod) : acc + acc_t'(prod);
		end
		if ((state != corr_idle) && slot_end) begin
			word <= acc;
		end
	end

	// ====================
	// slot sequencer
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= corr_idle;
			cnt <= '0;
			x <= '0;
			y <= '0;
			word_load <= 1'b0;
			last <= 1'b0;
			done <= 1'b0;
		end else begin
			word_load <= 1'b0;
			last <= 1'b0;
			done <= 1'b0;
			if (state != corr_idle) begin
				cnt <= slot_end ? '0 : cnt + 1'b1;
			end
			case (state)
				corr_idle: begin
					if (start) begin
						state <= corr_fetch;
						cnt <= '0;
						x <= '0;
						y <= '0;
					end
				end
				corr_fetch: begin
					if (slot_end) begin
						// previous pixel leaves, next one already fetching
						word_load <= 1'b1;
						if (x == side - side_t'(1)) begin
							x <= '0;
							y <= y + side_t'(1);
						end else begin
							x <= x + side_t'(1);
						end
					end
					if (last_px && (cnt == ($bits(cnt))'(`TMIP_TAPS-1))) begin
						state <= corr_drain;
					end
				end
				corr_drain: begin
					if (slot_end) begin
						word_load <= 1'b1;
						last <= 1'b1;
						done <= 1'b1;
						state <= corr_idle;
					end
				end
				default: state <= corr_idle;
			endcase
		end
	end

endmodule

/* logic/frame_ram.sv */
`timescale 1ns/10ps
`include "tmip_defines.svh"

module frame_ram
	import tmip_pkg::*;
(
	input logic clk,
	input logic wr_en,
	input addr_t wr_addr,
	input pix_t wr_data,
	input addr_t rd_addr,
	output pix_t rd_data
);

	// one grayscale plane, raster order
	pix_t mem [0:`TMIP_MAX_SIDE*`TMIP_MAX_SIDE-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	// loader must present a clean address with every write
	a_wr_addr_known: assert property (
		@(posedge clk) wr_en |-> !$isunknown(wr_addr)
	);

endmodule

/* logic/pixel_loader.sv */
`timescale 1ns/10ps
`include "tmip_defines.svh"

module pixel_loader
	import tmip_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input pix_t image,
	input pix_t template,
	input logic [1:0] image_size,
	output logic wr_en,
	output addr_t wr_addr,
	output pix_t gray_max_px,
	output pix_t gray_avg_px,
	output pix_t gray_wgt_px,
	output side_t side,
	output pix_t weights [`TMIP_TAPS]
);

	logic first;
	logic [1:0] rgb_cnt;
	tap_t tap_cnt;
	pix_t px_r;
	pix_t px_g;
	pix_t px_b;
	logic px_ready;
	addr_t last_addr;
	pix_t px_max;
	logic [`TMIP_PIX_W+1:0] rgb_sum;
	logic [`TMIP_PIX_W+1:0] rgb_avg;

	// tap counter idles at 0 between bursts
	assign first = in_valid && (tap_cnt == '0);

	// ====================
	// burst capture
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_cnt <= '0;
			rgb_cnt <= 2'd0;
			px_ready <= 1'b0;
			side <= side_t'(4);
			last_addr <= addr_t'(15);
		end else begin
			px_ready <= in_valid && (rgb_cnt == 2'd2);
			if (!in_valid) begin
				tap_cnt <= '0;
				rgb_cnt <= 2'd0;
			end else begin
				if (tap_cnt != tap_t'(`TMIP_TAPS)) begin
					tap_cnt <= tap_cnt + tap_t'(1);
				end
				rgb_cnt <= (rgb_cnt == 2'd2) ? 2'd0 : rgb_cnt + 2'd1;
			end
			if (first) begin
				case (image_size)
					2'd1: begin
						side <= side_t'(8);
						last_addr <= addr_t'(63);
					end
					2'd2: begin
						side <= side_t'(16);
						last_addr <= addr_t'(255);
					end
					default: begin
						side <= side_t'(4);
						last_addr <= addr_t'(15);
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && (tap_cnt < tap_t'(`TMIP_TAPS))) begin
			weights[tap_cnt] <= template;
		end
		if (in_valid) begin
			case (rgb_cnt)
				2'd0: px_r <= image;
				2'd1: px_g <= image;
				default: px_b <= image;
			endcase
		end
	end

	// ====================
	// gray conversion
	// ====================
	assign px_max = (px_r >= px_g && px_r >= px_b) ? px_r : (px_g >= px_b) ? px_g : px_b;
	assign rgb_sum = {2'b00, px_r} + {2'b00, px_g} + {2'b00, px_b};
	assign rgb_avg = rgb_sum / 3;

	always_ff @(posedge clk) begin
		if (px_ready) begin
			gray_max_px <= px_max;
			gray_avg_px <= rgb_avg[`TMIP_PIX_W-1:0];
			gray_wgt_px <= (px_r >> 2) + (px_g >> 1) + (px_b >> 2);
		end
	end

	// write strobe and raster address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
			wr_addr <= '0;
		end else begin
			wr_en <= px_ready;
			if (wr_en) begin
				wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + addr_t'(1);
			end else if (first) begin
				wr_addr <= '0;
			end
		end
	end

	a_size_legal: assert property (
		@(posedge clk) disable iff (!rst_n) first |-> (image_size != 2'd3)
	);

endmodule

/* logic/serial_out.sv */
`timescale 1ns/10ps
`include "tmip_defines.svh"

module serial_out
	import tmip_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input acc_t word,
	input logic word_load,
	input logic last,
	output logic out_valid,
	output logic out_value
);

	acc_t pending;
	acc_t shift;
	logic pend_vld;
	logic pend_last;
	logic shift_last;
	logic [$clog2(`TMIP_ACC_W)-1:0] bit_cnt;
	logic shift_free;

	// shift word empty or on its final bit
	assign shift_free = !out_valid || (bit_cnt == ($bits(bit_cnt))'(`TMIP_ACC_W-1));
	assign out_value = out_valid & shift[`TMIP_ACC_W-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			bit_cnt <= '0;
			pend_vld <= 1'b0;
			pend_last <= 1'b0;
			shift_last <= 1'b0;
		end else begin
			bit_cnt <= out_valid ? bit_cnt + 1'b1 : '0;
			if (word_load && shift_free) begin
				shift <= word;
				shift_last <= last;
				out_valid <= 1'b1;
				bit_cnt <= '0;
			end else if (shift_free && pend_vld) begin
				shift <= pending;
				shift_last <= pend_last;
				pend_vld <= 1'b0;
				out_valid <= 1'b1;
				bit_cnt <= '0;
			end else if (shift_free) begin
				out_valid <= 1'b0;
			end else begin
				shift <= shift << 1;
			end
			if (word_load && !shift_free) begin
				pending <= word;
				pend_last <= last;
				pend_vld <= 1'b1;
			end
		end
	end

	a_no_overrun: assert property (
		@(posedge clk) disable iff (!rst_n) word_load |-> !pend_vld
	);

	// words of one set arrive without a gap
	a_no_gap: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && shift_free && !shift_last) |-> (word_load || pend_vld)
	);

endmodule

/* logic/tmip_defines.svh */
`ifndef TMIP_DEFINES_SVH
`define TMIP_DEFINES_SVH

// ====================
// data widths
// ====================
`define TMIP_PIX_W 8
`define TMIP_ADDR_W 8
`define TMIP_ACC_W 20

// ====================
// image geometry
// ====================
`define TMIP_TAPS 9
`define TMIP_MAX_SIDE 16
// one output word per slot, one bit per cycle
`define TMIP_SLOT 20

`endif

/* logic/tmip_pkg.sv */
`include "tmip_defines.svh"

package tmip_pkg;

	// gray value, rgb byte or template weight
	typedef logic [`TMIP_PIX_W-1:0] pix_t;
	// plane address, raster order
	typedef logic [`TMIP_ADDR_W-1:0] addr_t;
	typedef logic [`TMIP_ACC_W-1:0] acc_t;
	// side in pixels, 4 / 8 / 16
	typedef logic [$clog2(`TMIP_MAX_SIDE+1)-1:0] side_t;
	// tap 0..8, row-major
	typedef logic [$clog2(`TMIP_TAPS)-1:0] tap_t;

	typedef enum logic [1:0] {
		gray_max = 2'd0,
		gray_avg = 2'd1,
		gray_wgt = 2'd2
	} gray_mode_e;

	typedef enum logic [2:0] {
		act_gray_max = 3'd0,
		act_gray_avg = 3'd1,
		act_gray_wgt = 3'd2,
		act_pool = 3'd3,
		act_neg = 3'd4,
		act_flip = 3'd5,
		act_filter = 3'd6,
		act_conv = 3'd7
	} action_e;

	typedef enum logic [1:0] {
		corr_idle,
		corr_fetch,
		corr_drain
	} corr_state_e;

endpackage

/* logic/tmip_top.sv */
`timescale 1ns/10ps
`include "tmip_defines.svh"

module tmip_top
	import tmip_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_valid2,
	input pix_t image,
	input pix_t template,
	input logic [1:0] image_size,
	input logic [2:0] action,
	output logic out_valid,
	output logic out_value
);

	logic wr_en;
	addr_t wr_addr;
	addr_t rd_addr;
	pix_t wr_max;
	pix_t wr_avg;
	pix_t wr_wgt;
	pix_t rd_max;
	pix_t rd_avg;
	pix_t rd_wgt;
	side_t side;
	pix_t weights [`TMIP_TAPS];
	gray_mode_e gray_mode;
	logic neg;
	logic flip;
	logic start;
	logic done;
	acc_t word;
	logic word_load;
	logic last;

	pixel_loader pixel_loader_i (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.image(image), .template(template), .image_size(image_size),
		.wr_en(wr_en), .wr_addr(wr_addr),
		.gray_max_px(wr_max), .gray_avg_px(wr_avg), .gray_wgt_px(wr_wgt),
		.side(side), .weights(weights)
	);

	// ====================
	// gray planes
	// ====================
	frame_ram ram_max_i (.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_max), .rd_addr(rd_addr), .rd_data(rd_max));
	frame_ram ram_avg_i (.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_avg), .rd_addr(rd_addr), .rd_data(rd_avg));
	frame_ram ram_wgt_i (.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_wgt), .rd_addr(rd_addr), .rd_data(rd_wgt));

	action_queue action_queue_i (
		.clk(clk), .rst_n(rst_n), .in_valid2(in_valid2), .action(action), .done(done),
		.gray_mode(gray_mode), .neg(neg), .flip(flip), .start(start)
	);

	corr_engine corr_engine_i (
		.clk(clk), .rst_n(rst_n), .start(start), .side(side), .weights(weights),
		.gray_mode(gray_mode), .neg(neg), .flip(flip),
		.gray_max_px(rd_max), .gray_avg_px(rd_avg), .gray_wgt_px(rd_wgt),
		.rd_addr(rd_addr), .word(word), .word_load(word_load), .last(last), .done(done)
	);

	serial_out serial_out_i (
		.clk(clk), .rst_n(rst_n), .word(word), .word_load(word_load), .last(last),
		.out_valid(out_valid), .out_value(out_value)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the tmip testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tmip.f \
	--top-module tmip_tb -Mdir obj_dir -o tmip_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tmip_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* tmip.f */
+incdir+logic
logic/tmip_pkg.sv
logic/frame_ram.sv
logic/pixel_loader.sv
logic/action_queue.sv
logic/corr_engine.sv
logic/serial_out.sv
logic/tmip_top.sv
verif/tmip_tb.sv

/* verif/tmip_tb.sv */
`timescale 1ns/10ps
`include "tmip_defines.svh"

module tmip_tb
	import tmip_pkg::*;
();

	localparam int NROWS = 5;
	localparam int RISE_TIMEOUT = 400;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_valid2;
	pix_t image;
	pix_t template;
	logic [1:0] image_size;
	logic [2:0] action;
	logic out_valid;
	logic out_value;

	// reference model state
	logic [31:0] img_state;
	int side_n;
	int tmpl [`TMIP_TAPS];
	int plane_max [256];
	int plane_avg [256];
	int plane_wgt [256];
	acc_t exp_words [256];

	// stimulus table
	// middle actions three bits each with the first in the low bits
	int nrows;
	logic [1:0] row_size [NROWS];
	bit row_load [NROWS];
	gray_mode_e row_gm [NROWS];
	logic [11:0] row_mid [NROWS];
	int row_nmid [NROWS];
	int row_tseed [NROWS];

	tmip_top tmip_top_i (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
		.image(image), .template(template), .image_size(image_size), .action(action),
		.out_valid(out_valid), .out_value(out_value)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic pix_t next_byte();
		img_state = lcg_step(img_state);
		return img_state[23:16];
	endfunction

	function automatic int plane_value(input gray_mode_e gm, input int idx);
		case (gm)
			gray_avg: return plane_avg[idx];
			gray_wgt: return plane_wgt[idx];
			default: return plane_max[idx];
		endcase
	endfunction

	// ====================
	// compare tasks
	// ====================
	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "bit compare failed");
		end
	endtask

	task automatic check_word(input acc_t got, input acc_t exp, input string name);
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "word compare failed");
		end
	endtask

	task automatic add_row(input logic [1:0] size_code, input bit load, input gray_mode_e gm,
		input logic [11:0] mids, input int nmid, input int tseed);
		row_size[nrows] = size_code;
		row_load[nrows] = load;
		row_gm[nrows] = gm;
		row_mid[nrows] = mids;
		row_nmid[nrows] = nmid;
		row_tseed[nrows] = tseed;
		nrows++;
	endtask

	// ====================
	// stimulus
	// ====================
	task automatic load_image(input logic [1:0] code, input int tseed);
		logic [31:0] ts;
		int px_r [256];
		int px_g [256];
		int px_b [256];
		int mx;
		int n;
		n = 4 << code;
		side_n = n;
		ts = tseed;
		for (int k = 0; k < `TMIP_TAPS; k++) begin
			ts = lcg_step(ts);
			tmpl[k] = int'(ts[23:16]);
		end
		for (int p = 0; p < n * n; p++) begin
			px_r[p] = int'(next_byte());
			px_g[p] = int'(next_byte());
			px_b[p] = int'(next_byte());
			mx = px_r[p];
			if (px_g[p] > mx) mx = px_g[p];
			if (px_b[p] > mx) mx = px_b[p];
			plane_max[p] = mx;
			plane_avg[p] = (px_r[p] + px_g[p] + px_b[p]) / 3;
			plane_wgt[p] = px_r[p] / 4 + px_g[p] / 2 + px_b[p] / 4;
		end
		for (int i = 0; i < 3 * n * n; i++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			image_size <= (i == 0) ? code : 2'd0;
			template <= (i < `TMIP_TAPS) ? pix_t'(tmpl[i]) : '0;
			case (i % 3)
				0: image <= pix_t'(px_r[i / 3]);
				1: image <= pix_t'(px_g[i / 3]);
				default: image <= pix_t'(px_b[i / 3]);
			endcase
		end
		@(posedge clk);
		in_valid <= 1'b0;
		image <= '0;
		template <= '0;
		// let the last plane write land
		repeat (4) @(posedge clk);
	endtask

	task automatic send_set(input gray_mode_e gm, input logic [11:0] mids, input int nmid);
		@(posedge clk);
		in_valid2 <= 1'b1;
		action <= {1'b0, gm};
		for (int k = 0; k < nmid; k++) begin
			@(posedge clk);
			action <= mids[3*k +: 3];
		end
		@(posedge clk);
		action <= act_conv;
		@(posedge clk);
		in_valid2 <= 1'b0;
		action <= 3'd0;
	endtask

	// zero-padded 3x3 correlation on the transformed plane
	task automatic compute_expected(input gray_mode_e gm, input bit neg, input bit flip);
		int acc;
		int sy;
		int sx;
		int col;
		int p;
		for (int y = 0; y < side_n; y++) begin
			for (int x = 0; x < side_n; x++) begin
				acc = 0;
				for (int r = 0; r < 3; r++) begin
					for (int c = 0; c < 3; c++) begin
						sy = y + r - 1;
						sx = x + c - 1;
						if (sy >= 0 && sy < side_n && sx >= 0 && sx < side_n) begin
							col = flip ? side_n - 1 - sx : sx;
							p = plane_value(gm, sy * side_n + col);
							if (neg) p = 255 - p;
							acc += tmpl[r * 3 + c] * p;
						end
					end
				end
				exp_words[y * side_n + x] = acc_t'(acc);
			end
		end
	endtask

	// ====================
	// output checks
	// ====================
	task automatic check_stream();
		int waited;
		acc_t w;
		waited = 0;
		w = '0;
		@(negedge clk);
		while (!out_valid) begin
			if (waited == RISE_TIMEOUT) begin
				$display("out_valid never rose after the conv action");
				$display("TEST FAILED");
				$fatal(1, "timeout waiting for output");
			end
			waited++;
			@(negedge clk);
		end
		// bits must run back to back with no gap
		for (int k = 0; k < `TMIP_ACC_W * side_n * side_n; k++) begin
			check_bit(out_valid, 1'b1, "out_valid");
			w = {w[`TMIP_ACC_W-2:0], out_value};
			if (k % `TMIP_ACC_W == `TMIP_ACC_W - 1) begin
				check_word(w, exp_words[k / `TMIP_ACC_W],
					$sformatf("out_value word %0d", k / `TMIP_ACC_W));
			end
			@(negedge clk);
		end
		check_bit(out_valid, 1'b0, "out_valid");
		check_bit(out_value, 1'b0, "out_value");
	endtask

	task automatic idle_check(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_bit(out_valid, 1'b0, "out_valid");
			check_bit(out_value, 1'b0, "out_value");
		end
	endtask

	initial begin
		bit neg_p;
		bit flip_p;
		logic [2:0] code;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_valid2 = 1'b0;
		image = '0;
		template = '0;
		image_size = 2'd0;
		action = 3'd0;
		img_state = 32'd34;
		nrows = 0;

		add_row(2'd0, 1'b1, gray_max, 12'd0, 0, 11);
		add_row(2'd1, 1'b1, gray_avg, 12'(act_neg), 1, 23);
		add_row(2'd2, 1'b1, gray_wgt, 12'({act_flip, act_neg, act_flip}), 3, 37);
		// same stored image from here on
		add_row(2'd2, 1'b0, gray_max, 12'({act_neg, act_neg}), 2, 0);
		add_row(2'd2, 1'b0, gray_avg, 12'({act_filter, act_flip, act_pool}), 3, 0);

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		idle_check(10);

		for (int i = 0; i < nrows; i++) begin
			if (row_load[i]) begin
				load_image(row_size[i], row_tseed[i]);
			end
			neg_p = 1'b0;
			flip_p = 1'b0;
			for (int k = 0; k < row_nmid[i]; k++) begin
				code = row_mid[i][3*k +: 3];
				if (code == act_neg) neg_p = !neg_p;
				if (code == act_flip) flip_p = !flip_p;
			end
			compute_expected(row_gm[i], neg_p, flip_p);
			send_set(row_gm[i], row_mid[i], row_nmid[i]);
			check_stream();
			idle_check(3);
		end

		$display("TEST OK");
		$finish;
	end

endmodule
